//--- flist.f
+incdir+tb
hw/bpred_pkg.sv
hw/block_ram_with_reset.sv
hw/gshare_pht.sv
hw/branch_target_buffer.sv
hw/branch_predictor.sv
tb/tb_branch_predictor.sv

//--- Bender.yml
package:
  name: branch_predictor

sources:
  # RTL, package first
  - files:
      - hw/bpred_pkg.sv
      - hw/block_ram_with_reset.sv
      - hw/gshare_pht.sv
      - hw/branch_target_buffer.sv
      - hw/branch_predictor.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_branch_predictor.sv

//--- tb/bpred_model.svh
/*
 * Reference model of the predictor tables and global history
 */
`ifndef BPRED_MODEL_SVH
`define BPRED_MODEL_SVH

// Mirrors of the PHT, BTB and history
ctr_e                 pht_mirror [1 << pht_index_width];
btb_entry_t           btb_mirror [1 << btb_index_width];
logic [ghr_width-1:0] ghr_mirror;

// Tables as they stand after the clear
function automatic void clear_mirror();
    foreach (pht_mirror[i]) begin
        pht_mirror[i] = strong_nt;
    end
    foreach (btb_mirror[i]) begin
        btb_mirror[i] = '0;
    end
    ghr_mirror = '0;
endfunction

// One saturating step toward the outcome
function automatic ctr_e step_counter(input ctr_e c, input logic taken);
    if (taken) begin
        return (c == strong_t) ? strong_t : ctr_e'(c + 2'd1);
    end
    return (c == strong_nt) ? strong_nt : ctr_e'(c - 2'd1);
endfunction

// Expected response for a lookup of pc against the current mirrors
function automatic pred_resp_t predict_response(input logic [pc_width-1:0] pc);
    pred_resp_t r;
    btb_entry_t e;
    r.pc = pc;
    r.pht_index = pc[pht_index_width+1:2] ^ ghr_mirror;
    r.ctr = pht_mirror[r.pht_index];
    e = btb_mirror[pc[btb_index_width+1:2]];
    r.btb_hit = e.valid && (e.tag == pc[pc_width-1:btb_index_width+2]);
    // Jumps ignore the counter, conditionals need weak_t or strong_t
    r.taken = r.btb_hit && (e.kind == br_jump || r.ctr == weak_t || r.ctr == strong_t);
    r.target = r.taken ? e.target : pc + 32'd4;
    return r;
endfunction

// Resolved branch, applied in acceptance order
function automatic void apply_update(input upd_req_t u);
    if (u.kind == br_cond) begin
        pht_mirror[u.pht_index] = step_counter(u.ctr, u.taken);
        ghr_mirror = {ghr_mirror[ghr_width-2:0], u.taken};
    end
    if (u.taken) begin
        btb_mirror[u.pc[btb_index_width+1:2]].valid = 1'b1;
        btb_mirror[u.pc[btb_index_width+1:2]].kind = u.kind;
        btb_mirror[u.pc[btb_index_width+1:2]].tag = u.pc[pc_width-1:btb_index_width+2];
        btb_mirror[u.pc[btb_index_width+1:2]].target = u.target;
    end
endfunction

`endif

//--- tb/tb_branch_predictor.sv
/*
 * Testbench for the branch predictor
 * Directed table tests, then a random mix under response back-pressure
 */
`timescale 1ns/1ps

module tb_branch_predictor;

    import bpred_pkg::*;

    `include "bpred_model.svh"

    // Clear of 256 plus about 2000 operations at up to four cycles each
    localparam int cycle_limit = 20000;
    localparam int random_ops = 1500;
    // History filler, BTB index 3f is used by no directed test
    localparam logic [31:0] filler_pc = 32'h0000_70fc;

    logic       clk;
    logic       rst;
    logic       req_valid;
    pred_req_t  req;
    logic       req_ready;
    logic       resp_valid;
    pred_resp_t resp;
    logic       resp_ready;
    logic       upd_valid;
    upd_req_t   upd;
    logic       upd_ready;

    pred_resp_t  expected_q [$];
    pred_resp_t  held_resp;
    pred_resp_t  last_resp;
    logic        hold_pending;
    logic        stall_mode;
    logic [31:0] rand_state;
    logic [31:0] ready_state;
    int          errors;
    int          checks;
    int          tests;
    int          err_base;
    int          cycle_count = 0;

    branch_predictor DUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_random();
        rand_state = lcg_step(rand_state);
        return rand_state;
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    // Lookup held until accepted, expectation taken at that edge
    task automatic lookup(input logic [pc_width-1:0] pc);
        req.pc = pc;
        req_valid = 1'b1;
        @(posedge clk);
        while (req_ready !== 1'b1) begin
            @(posedge clk);
        end
        expected_q.push_back(predict_response(pc));
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // Update carries index and counter as a prediction made now would
    task automatic send_update(input logic [31:0] pc, input br_kind_e kind, input logic taken,
                               input logic [31:0] target);
        pred_resp_t seen;
        upd_req_t   u;
        seen = predict_response(pc);
        u.pc = pc;
        u.kind = kind;
        u.taken = taken;
        u.target = target;
        u.pht_index = seen.pht_index;
        u.ctr = seen.ctr;
        upd = u;
        upd_valid = 1'b1;
        @(posedge clk);
        while (upd_ready !== 1'b1) begin
            @(posedge clk);
        end
        apply_update(u);
        @(negedge clk);
        upd_valid = 1'b0;
    endtask

    // Eight conditional outcomes, oldest first
    task automatic set_history(input logic [7:0] h);
        for (int i = ghr_width - 1; i >= 0; i--) begin
            send_update(filler_pc, br_cond, h[i], filler_pc + 32'h100);
        end
    endtask

    // Returns once every outstanding lookup has been answered
    task automatic wait_responses();
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic close_test(input string name);
        wait_responses();
        tests++;
        $display("Test %0d %s done, %0d errors", tests, name, errors - err_base);
        err_base = errors;
    endtask

    // ==================================================
    // Response checking
    // ==================================================

    always @(posedge clk) begin
        pred_resp_t exp_resp;
        if (!rst && resp_valid === 1'b1) begin
            // Stalled response must not move
            if (hold_pending) begin
                check("resp", resp, held_resp);
            end
            if (resp_ready) begin
                hold_pending = 1'b0;
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("Response arrived with no lookup outstanding");
                end else begin
                    exp_resp = expected_q.pop_front();
                    last_resp = resp;
                    check("resp.pc", resp.pc, exp_resp.pc);
                    check("resp.taken", resp.taken, exp_resp.taken);
                    check("resp.target", resp.target, exp_resp.target);
                    check("resp.btb_hit", resp.btb_hit, exp_resp.btb_hit);
                    check("resp.pht_index", resp.pht_index, exp_resp.pht_index);
                    check("resp.ctr", resp.ctr, exp_resp.ctr);
                end
            end else begin
                held_resp = resp;
                hold_pending = 1'b1;
            end
        end else begin
            hold_pending = 1'b0;
        end
    end

    // Random back-pressure, own stream so it does not shift the stimulus
    always @(negedge clk) begin
        if (stall_mode) begin
            ready_state = lcg_step(ready_state);
            resp_ready = (ready_state[31:30] != 2'b00);
        end else begin
            resp_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================

    initial begin
        logic [31:0] r;
        logic [31:0] pc;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b1;
        upd_valid = 1'b0;
        upd = '0;
        hold_pending = 1'b0;
        stall_mode = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        err_base = 0;
        rand_state = 32'h398f;
        ready_state = ~rand_state;
        clear_mirror();
        repeat (2) @(negedge clk);
        check("req_ready", req_ready, 1'b0);
        check("upd_ready", upd_ready, 1'b0);
        check("resp_valid", resp_valid, 1'b0);
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Cleared tables, 64 distinct BTB indices
        while (req_ready !== 1'b1) begin
            @(negedge clk);
        end
        for (int i = 0; i < 64; i++) begin
            r = next_random();
            lookup({r[31:8], 6'(i), 2'b00});
        end
        close_test("cleared tables");

        // History fills with ones, then with zeros
        pc = 32'h0000_1040;
        for (int i = 0; i < 14; i++) begin
            send_update(pc, br_cond, 1'b1, 32'h0000_2000);
            lookup(pc);
        end
        wait_responses();
        check("resp.ctr", last_resp.ctr, strong_t);
        check("resp.taken", last_resp.taken, 1'b1);
        for (int i = 0; i < 14; i++) begin
            send_update(pc, br_cond, 1'b0, 32'h0000_2000);
            lookup(pc);
        end
        wait_responses();
        check("resp.ctr", last_resp.ctr, strong_nt);
        check("resp.taken", last_resp.taken, 1'b0);
        close_test("counter saturation");

        pc = 32'h0000_3080;
        send_update(pc, br_jump, 1'b1, 32'h0000_5550);
        repeat (4) lookup(pc);
        wait_responses();
        check("resp.taken", last_resp.taken, 1'b1);
        check("resp.target", last_resp.target, 32'h0000_5550);
        close_test("jump target");

        // Same index 04, tags differ
        send_update(32'h0000_4010, br_jump, 1'b1, 32'h0000_a000);
        lookup(32'h0000_4010);
        lookup(32'h0000_8010);
        send_update(32'h0000_8010, br_jump, 1'b1, 32'h0000_b000);
        lookup(32'h0000_4010);
        wait_responses();
        check("resp.btb_hit", last_resp.btb_hit, 1'b0);
        lookup(32'h0000_8010);
        wait_responses();
        check("resp.btb_hit", last_resp.btb_hit, 1'b1);
        close_test("btb aliasing");

        // Taken under history 00, not taken under a5
        pc = 32'h0000_6104;
        for (int i = 0; i < 3; i++) begin
            set_history(8'h00);
            send_update(pc, br_cond, 1'b1, 32'h0000_6800);
            set_history(8'ha5);
            send_update(pc, br_cond, 1'b0, 32'h0000_6800);
        end
        set_history(8'h00);
        lookup(pc);
        wait_responses();
        check("resp.ctr", last_resp.ctr, strong_t);
        check("resp.taken", last_resp.taken, 1'b1);
        set_history(8'ha5);
        lookup(pc);
        wait_responses();
        check("resp.ctr", last_resp.ctr, strong_nt);
        check("resp.taken", last_resp.taken, 1'b0);
        close_test("history separation");

        @(posedge clk);
        stall_mode = 1'b1;
        @(negedge clk);
        for (int i = 0; i < random_ops; i++) begin
            r = next_random();
            // 64 PCs over 16 BTB indices
            pc = 32'h0002_0000 | (r & 32'h0000_0c3c);
            if (r[31:30] == 2'b00) begin
                send_update(pc, br_kind_e'(r[29]), r[28], {16'h0003, r[27:14], 2'b00});
            end else begin
                lookup(pc);
            end
        end
        @(posedge clk);
        stall_mode = 1'b0;
        close_test("random mix with back-pressure");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- hw/branch_predictor.sv
/*
 * Front-end branch predictor top
 * Clear sequencing, update-over-lookup arbitration, response forming
 */
`timescale 1ns/1ps

module branch_predictor (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    input  bpred_pkg::pred_req_t  req,
    output logic                  req_ready,
    output logic                  resp_valid,
    output bpred_pkg::pred_resp_t resp,
    input  logic                  resp_ready,
    input  logic                  upd_valid,
    input  bpred_pkg::upd_req_t   upd,
    output logic                  upd_ready
);

    import bpred_pkg::*;

    // ==================================================
    // Clear sequence
    // ==================================================

    // Stretches a short rst over every table entry
    logic                         clear_busy;
    logic [clear_count_width-1:0] clear_count;
    logic                         table_clear;

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_busy <= 1'b1;
            clear_count <= '0;
        end else if (clear_busy) begin
            clear_count <= clear_count + 1'b1;
            if (clear_count == clear_count_width'(clear_cycles - 1)) begin
                clear_busy <= 1'b0;
            end
        end
    end

    // RAMs clear during rst and the stretch after it
    assign table_clear = rst || clear_busy;

    // ==================================================
    // Arbitration
    // ==================================================

    logic stall;
    logic req_fire;
    logic upd_fire;

    // Response held by the consumer
    assign stall = resp_valid && !resp_ready;

    // Update wins the shared RAM ports
    assign upd_ready = !clear_busy && !stall;
    assign req_ready = !clear_busy && !stall && !upd_valid;

    assign req_fire = req_valid && req_ready;
    assign upd_fire = upd_valid && upd_ready;

    // ==================================================
    // Response tracking
    // ==================================================

    logic [pc_width-1:0] pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_fire || stall;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            pc_q <= req.pc;
        end
    end

    // ==================================================
    // Tables
    // ==================================================

    ctr_e                       pht_ctr;
    logic [pht_index_width-1:0] pht_index;
    logic                       btb_hit;
    br_kind_e                   btb_kind;
    logic [pc_width-1:0]        btb_target;

    gshare_pht u_pht (
        .clk         (clk),
        .rst         (rst),
        .clear       (table_clear),
        .lookup_valid(req_fire),
        .lookup_pc   (req.pc),
        .write_valid (upd_fire),
        .write       (upd),
        .ctr         (pht_ctr),
        .index       (pht_index)
    );

    branch_target_buffer u_btb (
        .clk         (clk),
        .clear       (table_clear),
        .lookup_valid(req_fire),
        .lookup_pc   (req.pc),
        .write_valid (upd_fire),
        .write       (upd),
        .hit         (btb_hit),
        .kind        (btb_kind),
        .target      (btb_target)
    );

    // ==================================================
    // Prediction
    // ==================================================

    // Needs a BTB hit, then a jump or a taken-leaning counter
    logic taken;
    assign taken = btb_hit && ((btb_kind == br_jump) || (pht_ctr >= weak_t));

    always_comb begin
        resp.pc = pc_q;
        resp.taken = taken;
        resp.target = taken ? btb_target : pc_q + pc_width'(4);
        resp.btb_hit = btb_hit;
        resp.pht_index = pht_index;
        resp.ctr = pht_ctr;
    end

    // No response can come out of a table that is still clearing
    assert property (@(posedge clk) disable iff (rst) table_clear |=> !resp_valid);

    // Tables re-read held indices, so a stalled response is steady
    assert property (@(posedge clk) disable iff (table_clear) stall |=> $stable(resp));

endmodule

//--- hw/branch_target_buffer.sv
/*
 * Branch target buffer
 * Tagged table of branch kind and target, direct mapped on PC bits 7:2
 */
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                           clk,
    input  logic                           clear,
    input  logic                           lookup_valid,
    input  logic [bpred_pkg::pc_width-1:0] lookup_pc,
    input  logic                           write_valid,
    input  bpred_pkg::upd_req_t            write,
    output logic                           hit,
    output bpred_pkg::br_kind_e            kind,
    output logic [bpred_pkg::pc_width-1:0] target
);

    import bpred_pkg::*;

    // ==================================================
    // Address split
    // ==================================================

    // Index sits just above the byte offset
    logic [btb_index_width-1:0] lookup_index;
    logic [btb_tag_width-1:0]   lookup_tag;
    logic [btb_index_width-1:0] write_index;
    logic [btb_tag_width-1:0]   write_tag;

    assign lookup_index = lookup_pc[btb_index_width+1:2];
    assign lookup_tag = lookup_pc[pc_width-1:btb_index_width+2];
    assign write_index = write.pc[btb_index_width+1:2];
    assign write_tag = write.pc[pc_width-1:btb_index_width+2];

    // ==================================================
    // Lookup registers
    // ==================================================

    // Held while idle so a stalled response keeps its data
    logic [btb_index_width-1:0] index_q;
    logic [btb_tag_width-1:0]   tag_q;

    always_ff @(posedge clk) begin
        if (clear) begin
            index_q <= '0;
            tag_q <= '0;
        end else if (lookup_valid) begin
            index_q <= lookup_index;
            tag_q <= lookup_tag;
        end
    end

    // RAM address for this cycle
    logic [btb_index_width-1:0] ram_index;

    always_comb begin
        if (lookup_valid) begin
            ram_index = lookup_index;
        end else if (write_valid) begin
            ram_index = write_index;
        end else begin
            ram_index = index_q;
        end
    end

    // ==================================================
    // Entry write
    // ==================================================

    // Only taken branches allocate
    logic       ram_write;
    btb_entry_t new_entry;

    assign ram_write = write_valid && write.taken;

    always_comb begin
        new_entry.valid = 1'b1;
        new_entry.kind = write.kind;
        new_entry.tag = write_tag;
        new_entry.target = write.target;
    end

    // ==================================================
    // Storage and hit
    // ==================================================

    btb_entry_t rd_entry;

    block_ram_with_reset #(
        .data_width ($bits(btb_entry_t)),
        .index_width(btb_index_width)
    ) u_ram (
        .clk         (clk),
        .rst         (clear),
        .index       (ram_index),
        .write_value (new_entry),
        .write_enable(ram_write),
        .read_value  (rd_entry)
    );

    // Valid entry with matching tag
    assign hit = rd_entry.valid && (rd_entry.tag == tag_q);
    assign kind = rd_entry.kind;
    assign target = rd_entry.target;

endmodule

//--- hw/gshare_pht.sv
/*
 * Gshare pattern history table
 * Global history XOR PC word bits selects a two-bit counter
 */
`timescale 1ns/1ps

module gshare_pht (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     clear,
    input  logic                                     lookup_valid,
    input  logic [bpred_pkg::pc_width-1:0]           lookup_pc,
    input  logic                                     write_valid,
    input  bpred_pkg::upd_req_t                      write,
    output bpred_pkg::ctr_e                          ctr,
    output logic [bpred_pkg::pht_index_width-1:0]    index
);

    import bpred_pkg::*;

    // ==================================================
    // Global history
    // ==================================================

    logic [ghr_width-1:0] ghr;

    // Only resolved conditional branches shift in
    logic ghr_shift;
    assign ghr_shift = write_valid && (write.kind == br_cond);

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
        end else if (ghr_shift) begin
            ghr <= {ghr[ghr_width-2:0], write.taken};
        end
    end

    // ==================================================
    // Index selection
    // ==================================================

    // Hash of word address bits and history
    logic [pht_index_width-1:0] lookup_index;
    assign lookup_index = lookup_pc[pht_index_width+1:2] ^ ghr;

    // Last lookup index, re-read while idle
    logic [pht_index_width-1:0] index_q;

    always_ff @(posedge clk) begin
        if (clear) begin
            index_q <= '0;
        end else if (lookup_valid) begin
            index_q <= lookup_index;
        end
    end

    // RAM address for this cycle
    logic [pht_index_width-1:0] ram_index;

    always_comb begin
        if (lookup_valid) begin
            ram_index = lookup_index;
        end else if (write_valid) begin
            // Update carries the index used at prediction time
            ram_index = write.pht_index;
        end else begin
            ram_index = index_q;
        end
    end

    // ==================================================
    // Counter update
    // ==================================================

    // Carried counter moved one step toward the outcome
    ctr_e ctr_next;

    always_comb begin
        case (write.ctr)
            strong_nt: ctr_next = write.taken ? weak_nt : strong_nt;
            weak_nt:   ctr_next = write.taken ? weak_t : strong_nt;
            weak_t:    ctr_next = write.taken ? strong_t : weak_nt;
            default:   ctr_next = write.taken ? strong_t : weak_t;
        endcase
    end

    // Jumps leave the counter alone
    logic ram_write;
    assign ram_write = write_valid && (write.kind == br_cond);

    // ==================================================
    // Counter storage
    // ==================================================

    logic [1:0] ram_read;

    block_ram_with_reset #(
        .data_width (2),
        .index_width(pht_index_width)
    ) u_ram (
        .clk         (clk),
        .rst         (clear),
        .index       (ram_index),
        .write_value (ctr_next),
        .write_enable(ram_write),
        .read_value  (ram_read)
    );

    assign ctr = ctr_e'(ram_read);
    assign index = index_q;

    // Top arbitration keeps the single port to one user per cycle
    assert property (@(posedge clk) disable iff (rst)
        !(lookup_valid && write_valid));

endmodule

//--- hw/block_ram_with_reset.sv
/*
 * Single-port RAM, one-cycle read, one write per cycle
 * Holding rst walks a zero write over every entry
 */
`timescale 1ns/1ps

module block_ram_with_reset #(
    parameter int data_width = 2,
    parameter int index_width = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [index_width-1:0] index,
    input  logic [data_width-1:0]  write_value,
    input  logic                   write_enable,
    output logic [data_width-1:0]  read_value
);

    // Storage
    logic [data_width-1:0] body [1 << index_width];

    // Clear walk state
    logic                   rst_q;
    logic [index_width-1:0] clear_index;

    // Muxed write port
    logic                   wr_enable;
    logic [index_width-1:0] wr_index;
    logic [data_width-1:0]  wr_value;

    always_comb begin
        if (rst) begin
            wr_enable = 1'b1;
            wr_value = '0;
            // First cycle of a clear starts at entry zero
            if (rst_q) begin
                wr_index = clear_index;
            end else begin
                wr_index = '0;
            end
        end else begin
            wr_enable = write_enable;
            wr_value = write_value;
            wr_index = index;
        end
    end

    always_ff @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            clear_index <= wr_index + 1'b1;
        end

        // Read every cycle, old data on a same-index write
        read_value <= body[index];
        if (wr_enable) begin
            body[wr_index] <= wr_value;
        end
    end

    // Index must be known whenever the port is in normal use
    assert property (@(posedge clk) !rst |-> !$isunknown(index));

endmodule

//--- hw/bpred_pkg.sv
/*
 * Branch predictor shared definitions
 * Table geometry, counter and branch kind encodings, port payloads
 */
package bpred_pkg;

    // ==================================================
    // Geometry
    // ==================================================

    // Fetch address width
    localparam int pc_width = 32;

    // PHT of 256 two-bit counters
    localparam int pht_index_width = 8;
    localparam int ghr_width = 8;

    // BTB of 64 entries, tag is PC bits above index and byte offset
    localparam int btb_index_width = 6;
    localparam int btb_tag_width = 24;

    // Internal clear length covers the largest table
    localparam int clear_cycles = 256;
    localparam int clear_count_width = $clog2(clear_cycles);

    // ==================================================
    // Encodings
    // ==================================================

    // Saturating counter, all-zero is what a cleared entry holds
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_e;

    // Branch opcode stored in the BTB
    typedef enum logic {
        br_cond = 1'b0,
        br_jump = 1'b1
    } br_kind_e;

    // ==================================================
    // Payloads
    // ==================================================

    // BTB entry, 58 bits
    typedef struct packed {
        logic                     valid;
        br_kind_e                 kind;
        logic [btb_tag_width-1:0] tag;
        logic [pc_width-1:0]      target;
    } btb_entry_t;

    // Lookup request
    typedef struct packed {
        logic [pc_width-1:0] pc;
    } pred_req_t;

    // Lookup response, index and counter go back with the later update
    typedef struct packed {
        logic [pc_width-1:0]        pc;
        logic                       taken;
        logic [pc_width-1:0]        target;
        logic                       btb_hit;
        logic [pht_index_width-1:0] pht_index;
        ctr_e                       ctr;
    } pred_resp_t;

    // Resolved branch from execute
    typedef struct packed {
        logic [pc_width-1:0]        pc;
        br_kind_e                   kind;
        logic                       taken;
        logic [pc_width-1:0]        target;
        logic [pht_index_width-1:0] pht_index;
        ctr_e                       ctr;
    } upd_req_t;

endpackage
